//--- Makefile
TOP := tb_exception_unit

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- all.f
verilog/exc_pkg.sv
verilog/fault_capture.sv
verilog/fault_tracker.sv
verilog/exc_output.sv
verilog/exception_unit.sv
tb/tb_clock.sv
tb/exc_checker.sv
tb/exc_assert.sv
tb/tb_exception_unit.sv

//--- tb/exc_assert.sv
`timescale 1ns/1ps
`default_nettype none

module exc_assert (
    input logic clk,
    input logic rst_n,
    input logic exc_load,
    input logic pipe_reset,
    input logic shutdown
);

    // load strobe is a single cycle pulse
    load_single: assert property (@(posedge clk) disable iff (!rst_n)
        exc_load |=> !exc_load)
        else $error("exc_load high two cycles in a row");

    // pipe flushed in the decision cycle before the load
    load_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        exc_load |-> $past(pipe_reset))
        else $error("exc_load without pipe_reset in the cycle before");

    // shutdown is terminal, flush held with it
    shutdown_flush: assert property (@(posedge clk) disable iff (!rst_n)
        shutdown |=> (shutdown && pipe_reset))
        else $error("shutdown or pipe_reset dropped before reset");

endmodule

bind exception_unit exc_assert u_exc_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .exc_load   (exc_load),
    .pipe_reset (pipe_reset),
    .shutdown   (shutdown)
);

`default_nettype wire

//--- tb/exc_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exc_checker import exc_pkg::*; #(
    parameter int SHUTDOWN_DEPTH = 3
) (
    input  logic         clk,
    input  logic         rst_n,

    // DUT inputs
    input  stage_fault_t dec_fault,
    input  stage_fault_t rd_fault,
    input  stage_fault_t exe_fault,
    input  stage_fault_t wr_fault,
    input  logic         real_mode,
    input  logic         handler_done,

    // DUT outputs
    input  logic         exc_load,
    input  exc_event_t   exc_event,
    input  logic         shutdown,

    // running totals for the top
    output int           n_checked,
    output int           n_errors
);

    // predicted outcome of one captured fault
    typedef struct packed {
        logic       shut;
        exc_event_t ev;
    } expect_t;

    expect_t      expected;
    logic         busy;
    logic         halted;
    logic         shut_seen;
    int           count;
    fault_class_t last_type;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    function automatic fault_class_t classify(vector_t v);
        case (v)
            VEC_DE, VEC_TS, VEC_NP, VEC_SS, VEC_GP: return CLASS_CONTRIBUTORY;
            VEC_PF:  return CLASS_PAGE_FAULT;
            VEC_DF:  return CLASS_DOUBLE_FAULT;
            default: return CLASS_BENIGN;
        endcase
    endfunction

    function automatic logic qualified(stage_fault_t f);
        return f.valid && f.front;
    endfunction

    function automatic expect_t predict(input stage_fault_t dec, rd, exe, wr,
                                        input logic rm, input int cnt,
                                        input fault_class_t last);
        stage_fault_t f;
        logic         from_dec;
        logic         nested;
        fault_class_t cls;
        vector_t      vec;
        error_code_t  raw;
        expect_t      x;
        from_dec = 1'b0;
        // oldest stage first: write, execute, read, decode
        if (qualified(wr)) begin
            f = wr;
        end else if (qualified(exe)) begin
            f = exe;
        end else if (qualified(rd)) begin
            f = rd;
        end else begin
            f = dec;
            from_dec = 1'b1;
        end
        vec    = f.vector;
        raw    = f.error_code;
        cls    = classify(vec);
        nested = (cnt != 0);
        // too deep, or anything on top of a DF
        x.shut = (cnt >= SHUTDOWN_DEPTH) || (nested && last == CLASS_DOUBLE_FAULT);
        // benign never promotes
        if (nested && cls != CLASS_DOUBLE_FAULT &&
            ((last == CLASS_CONTRIBUTORY && cls == CLASS_CONTRIBUTORY) ||
             (last == CLASS_PAGE_FAULT &&
              (cls == CLASS_CONTRIBUTORY || cls == CLASS_PAGE_FAULT)))) begin
            vec = VEC_DF;
            raw = '0;
        end
        x.ev.vector = vec;
        // faults restart the instruction, traps resume after it
        if (from_dec || f.vector == VEC_BP || f.vector == VEC_OF) begin
            x.ev.eip = f.eip;
        end else begin
            x.ev.eip = f.eip - {28'd0, f.consumed};
        end
        if (rm) begin
            x.ev.error_code = '0;
        end else if (vec == VEC_PF || vec == VEC_DF) begin
            x.ev.error_code = raw;
        end else begin
            x.ev.error_code = {raw[15:1], nested};
        end
        x.ev.push_error = !rm &&
            (vec inside {VEC_DF, VEC_TS, VEC_NP, VEC_SS, VEC_GP, VEC_PF, VEC_AC});
        return x;
    endfunction

    // field by field, each wrong field gets its own line
    task automatic compare_event(input exc_event_t got, input exc_event_t want);
        if (got.vector !== want.vector) begin
            $display("Mismatch at %0t: vector got %0d expected %0d",
                     $time, got.vector, want.vector);
            n_errors++;
        end
        if (got.error_code !== want.error_code) begin
            $display("Mismatch at %0t: error_code got %h expected %h",
                     $time, got.error_code, want.error_code);
            n_errors++;
        end
        if (got.push_error !== want.push_error) begin
            $display("Mismatch at %0t: push_error got %0b expected %0b",
                     $time, got.push_error, want.push_error);
            n_errors++;
        end
        if (got.eip !== want.eip) begin
            $display("Mismatch at %0t: eip got %h expected %h",
                     $time, got.eip, want.eip);
            n_errors++;
        end
    endtask

    // ------------------------------------------------------------
    // compare process
    // ------------------------------------------------------------

    // busy from capture edge until the outcome shows up
    always @(posedge clk) begin
        if (!rst_n) begin
            busy      = 1'b0;
            halted    = 1'b0;
            shut_seen = 1'b0;
            count     = 0;
            last_type = CLASS_BENIGN;
            n_checked = 0;
            n_errors  = 0;
        end else begin
            if (exc_load) begin
                if (!busy) begin
                    $display("Error at %0t: exception load with no fault in flight", $time);
                    n_errors++;
                end else if (expected.shut) begin
                    $display("Mismatch at %0t: exception load, expected shutdown", $time);
                    n_errors++;
                end else begin
                    compare_event(exc_event, expected.ev);
                end
                n_checked++;
                busy = 1'b0;
            end else if (shutdown && !shut_seen) begin
                shut_seen = 1'b1;
                if (!busy || !expected.shut) begin
                    $display("Mismatch at %0t: shutdown raised, expected a delivery", $time);
                    n_errors++;
                end
                n_checked++;
                busy = 1'b0;
            end
            // nesting unwinds unless shut down
            if (handler_done && !halted) begin
                count = 0;
            end
            // same sampling rule as the DUT
            if (!busy && !halted && !shut_seen &&
                (qualified(wr_fault) || qualified(exe_fault) ||
                 qualified(rd_fault) || qualified(dec_fault))) begin
                expected = predict(dec_fault, rd_fault, exe_fault, wr_fault,
                                   real_mode, count, last_type);
                busy = 1'b1;
                if (expected.shut) begin
                    halted = 1'b1;
                end else begin
                    count++;
                    last_type = classify(expected.ev.vector);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // free running, starts low
    // half period per phase
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_exception_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exception_unit import exc_pkg::*; ();

    localparam int          SHUTDOWN_DEPTH = 3;
    localparam int          RESET_CYCLES   = 16;
    localparam int          STEP_WAIT      = 40;
    localparam int          N_RANDOM       = 12;
    // random, decode, codes, nesting, handler_done, shutdown
    localparam int          N_STEPS        = N_RANDOM + 1 + 12 + 6 + 2 + 4;
    localparam int          CYCLE_LIMIT    = N_STEPS * STEP_WAIT + RESET_CYCLES;
    localparam logic [31:0] SEED           = 32'h47c7b0d0;

    logic         clk;
    logic         rst_n;
    stage_fault_t dec_fault;
    stage_fault_t rd_fault;
    stage_fault_t exe_fault;
    stage_fault_t wr_fault;
    logic         real_mode;
    logic         handler_done;
    logic         exc_load;
    exc_event_t   exc_event;
    logic         pipe_reset;
    logic         shutdown;
    int           n_checked;
    int           n_errors;
    int           tb_errors;
    int           cycles;

    tb_clock #(.PERIOD_NS(100)) u_tb_clock (.clk(clk));

    exception_unit #(
        .SHUTDOWN_DEPTH (SHUTDOWN_DEPTH)
    ) u_exception_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_fault    (dec_fault),
        .rd_fault     (rd_fault),
        .exe_fault    (exe_fault),
        .wr_fault     (wr_fault),
        .real_mode    (real_mode),
        .handler_done (handler_done),
        .exc_load     (exc_load),
        .exc_event    (exc_event),
        .pipe_reset   (pipe_reset),
        .shutdown     (shutdown)
    );

    exc_checker #(
        .SHUTDOWN_DEPTH (SHUTDOWN_DEPTH)
    ) u_exc_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_fault    (dec_fault),
        .rd_fault     (rd_fault),
        .exe_fault    (exe_fault),
        .wr_fault     (wr_fault),
        .real_mode    (real_mode),
        .handler_done (handler_done),
        .exc_load     (exc_load),
        .exc_event    (exc_event),
        .shutdown     (shutdown),
        .n_checked    (n_checked),
        .n_errors     (n_errors)
    );

    // hard stop if a step never completes
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Error: run stopped after %0d cycles without finishing the tests", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------

    function automatic vector_t vector_at(logic [3:0] idx);
        case (idx)
            4'd0:    return VEC_DE;
            4'd1:    return VEC_DB;
            4'd2:    return VEC_BP;
            4'd3:    return VEC_OF;
            4'd4:    return VEC_BR;
            4'd5:    return VEC_UD;
            4'd6:    return VEC_NM;
            4'd7:    return VEC_DF;
            4'd8:    return VEC_TS;
            4'd9:    return VEC_NP;
            4'd10:   return VEC_SS;
            4'd11:   return VEC_GP;
            4'd12:   return VEC_PF;
            default: return VEC_AC;
        endcase
    endfunction

    // valid and front random, so some reports do not qualify
    function automatic stage_fault_t rand_fault();
        logic [31:0]  r;
        stage_fault_t f;
        r            = $urandom;
        f.valid      = r[0];
        f.front      = r[1];
        f.vector     = vector_at(r[7:4] % 4'd13 + {3'd0, r[8]});
        f.consumed   = r[19:16];
        f.error_code = r[31:16];
        f.eip        = $urandom;
        return f;
    endfunction

    function automatic stage_fault_t make_fault(vector_t v, error_code_t c);
        stage_fault_t f;
        f.valid      = 1'b1;
        f.front      = 1'b1;
        f.vector     = v;
        f.error_code = c;
        f.eip        = 32'h0000_4000 + {24'd0, v};
        f.consumed   = 4'd3;
        return f;
    endfunction

    // steps start and end 1 ns after a rising edge
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drop_faults();
        dec_fault = '0;
        rd_fault  = '0;
        exe_fault = '0;
        wr_fault  = '0;
    endtask

    // hold the fault until a load or shutdown, then release it
    task automatic raise(input stage_fault_t d, r, e, w);
        int   n;
        logic seen;
        dec_fault = d;
        rd_fault  = r;
        exe_fault = e;
        wr_fault  = w;
        n         = 0;
        seen      = 1'b0;
        while (!seen && n < STEP_WAIT) begin
            @(posedge clk);
            #1;
            n++;
            seen = exc_load || shutdown;
        end
        if (!seen) begin
            $display("Error at %0t: no exception load or shutdown within %0d cycles",
                     $time, STEP_WAIT);
            tb_errors++;
        end
        drop_faults();
        idle(1);
    endtask

    task automatic raise_exe(input vector_t v, input error_code_t c);
        raise('0, '0, make_fault(v, c), '0);
    endtask

    task automatic end_handler();
        handler_done = 1'b1;
        idle(1);
        handler_done = 1'b0;
        idle(2);
    endtask

    // push and no-push vectors, all delivered unnested
    task automatic code_round();
        raise_exe(VEC_GP, 16'h1235);
        end_handler();
        raise_exe(VEC_PF, 16'h0007);
        end_handler();
        raise_exe(VEC_DF, 16'h0003);
        end_handler();
        raise_exe(VEC_UD, 16'h00ff);
        end_handler();
        raise_exe(VEC_AC, 16'h0001);
        end_handler();
        raise_exe(VEC_BP, 16'h8001);
        end_handler();
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s finished, %0d errors so far", num, name, n_errors + tb_errors);
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin
        stage_fault_t d;
        stage_fault_t r;
        stage_fault_t e;
        stage_fault_t w;
        logic [31:0]  pick;
        int           loads;
        int           lost;
        rst_n        = 1'b0;
        real_mode    = 1'b0;
        handler_done = 1'b0;
        drop_faults();
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(2);

        // several stages at once, at least one qualified
        for (int i = 0; i < N_RANDOM; i++) begin
            d = rand_fault();
            r = rand_fault();
            e = rand_fault();
            w = rand_fault();
            if (!(d.valid && d.front) && !(r.valid && r.front) &&
                !(e.valid && e.front) && !(w.valid && w.front)) begin
                pick = $urandom;
                case (pick[1:0])
                    2'd0:    d.front = 1'b1;
                    2'd1:    r.front = 1'b1;
                    2'd2:    e.front = 1'b1;
                    default: w.front = 1'b1;
                endcase
                d.valid = d.valid | (pick[1:0] == 2'd0);
                r.valid = r.valid | (pick[1:0] == 2'd1);
                e.valid = e.valid | (pick[1:0] == 2'd2);
                w.valid = w.valid | (pick[1:0] == 2'd3);
            end
            raise(d, r, e, w);
            end_handler();
        end
        // decode alone keeps its eip
        raise(make_fault(VEC_NM, 16'h0000), '0, '0, '0);
        end_handler();
        report_test(1, "priority and eip");

        code_round();
        real_mode = 1'b1;
        code_round();
        real_mode = 1'b0;
        report_test(2, "error code and push");

        // benign on contributory, then two promotions
        raise_exe(VEC_GP, 16'h0010);
        raise_exe(VEC_UD, 16'h0000);
        end_handler();
        raise_exe(VEC_PF, 16'h0007);
        raise_exe(VEC_GP, 16'h0022);
        end_handler();
        raise_exe(VEC_TS, 16'h0031);
        raise_exe(VEC_NP, 16'h0044);
        end_handler();
        report_test(3, "nesting");

        // raw bit 0 set, must come back clear
        raise_exe(VEC_GP, 16'h0013);
        end_handler();
        raise_exe(VEC_SS, 16'h0101);
        end_handler();
        report_test(4, "handler done");

        // PF then GP gives DF, third fault shuts down
        raise_exe(VEC_PF, 16'h0002);
        raise_exe(VEC_GP, 16'h0004);
        raise_exe(VEC_UD, 16'h0000);
        if (!shutdown || !pipe_reset) begin
            $display("Error at %0t: shutdown and pipe reset not both raised", $time);
            tb_errors++;
        end
        wr_fault  = make_fault(VEC_GP, 16'h0008);
        dec_fault = make_fault(VEC_NM, 16'h0000);
        loads     = 0;
        lost      = 0;
        repeat (20) begin
            @(posedge clk);
            #1;
            if (exc_load) begin
                loads++;
            end
            if (!shutdown || !pipe_reset) begin
                lost++;
            end
        end
        drop_faults();
        if (loads != 0) begin
            $display("Error at %0t: %0d exception loads after shutdown", $time, loads);
            tb_errors++;
        end
        if (lost != 0) begin
            $display("Error at %0t: shutdown or pipe reset dropped for %0d cycles", $time, lost);
            tb_errors++;
        end
        idle(2);
        report_test(5, "shutdown");

        $display("checked %0d, checker errors %0d, testbench errors %0d",
                 n_checked, n_errors, tb_errors);
        if (n_errors + tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/exc_output.sv
`timescale 1ns/1ps
`default_nettype none

module exc_output import exc_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // from tracker
    input  logic       deliver,
    input  delivery_t  dlv,
    input  logic       halt,

    input  logic       real_mode,

    // to microcode
    output logic       exc_load,
    output exc_event_t exc_event,
    output logic       pipe_reset,
    output logic       shutdown
);

    logic        push_vec;
    error_code_t code_fmt;
    exc_event_t  event_nxt;

    // ------------------------------------------------------------
    // error code formatting
    // ------------------------------------------------------------

    // bit 0 is the external flag, set on a nested delivery
    always_comb begin
        if (real_mode) begin
            code_fmt = '0;
        end else if (dlv.vector == VEC_PF || dlv.vector == VEC_DF) begin
            code_fmt = dlv.error_code;
        end else begin
            code_fmt = {dlv.error_code[15:1], dlv.nested};
        end
    end

    // vectors that push an error code in protected mode
    assign push_vec = (dlv.vector == VEC_DF) || (dlv.vector == VEC_TS) ||
                      (dlv.vector == VEC_NP) || (dlv.vector == VEC_SS) ||
                      (dlv.vector == VEC_GP) || (dlv.vector == VEC_PF) ||
                      (dlv.vector == VEC_AC);

    always_comb begin
        event_nxt.vector     = dlv.vector;
        event_nxt.error_code = code_fmt;
        event_nxt.push_error = !real_mode && push_vec;
        event_nxt.eip        = dlv.eip;
    end

    // ------------------------------------------------------------
    // registered load
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exc_load <= 1'b0;
        end else begin
            exc_load <= deliver;
        end
    end

    always_ff @(posedge clk) begin
        if (deliver) begin
            exc_event <= event_nxt;
        end
    end

    // flush the pipe on delivery, hold it through shutdown
    assign pipe_reset = deliver || halt;
    assign shutdown   = halt;

endmodule

`default_nettype wire

//--- verilog/exc_pkg.sv
`default_nettype none

package exc_pkg;

    // ------------------------------------------------------------
    // widths with a meaning
    // ------------------------------------------------------------

    typedef logic [7:0]  vector_t;
    typedef logic [15:0] error_code_t;
    typedef logic [31:0] eip_t;
    // instruction bytes already taken by a stage
    typedef logic [3:0]  consumed_t;

    // ------------------------------------------------------------
    // architectural vector numbers
    // ------------------------------------------------------------

    localparam vector_t VEC_DE = 8'd0;
    localparam vector_t VEC_DB = 8'd1;
    localparam vector_t VEC_BP = 8'd3;
    localparam vector_t VEC_OF = 8'd4;
    localparam vector_t VEC_BR = 8'd5;
    localparam vector_t VEC_UD = 8'd6;
    localparam vector_t VEC_NM = 8'd7;
    localparam vector_t VEC_DF = 8'd8;
    localparam vector_t VEC_TS = 8'd10;
    localparam vector_t VEC_NP = 8'd11;
    localparam vector_t VEC_SS = 8'd12;
    localparam vector_t VEC_GP = 8'd13;
    localparam vector_t VEC_PF = 8'd14;
    localparam vector_t VEC_AC = 8'd17;

    // nesting classes used for double fault promotion
    typedef enum logic [1:0] {
        CLASS_BENIGN,
        CLASS_CONTRIBUTORY,
        CLASS_PAGE_FAULT,
        CLASS_DOUBLE_FAULT
    } fault_class_t;

    // ------------------------------------------------------------
    // fault records between blocks
    // ------------------------------------------------------------

    // per stage report, 62 bits
    typedef struct packed {
        logic        valid;
        logic        front;
        vector_t     vector;
        error_code_t error_code;
        eip_t        eip;
        consumed_t   consumed;
    } stage_fault_t;

    // winning fault with resolved eip, 56 bits
    typedef struct packed {
        vector_t     vector;
        error_code_t error_code;
        eip_t        eip;
    } fault_req_t;

    // decided fault, raw error code, 57 bits
    typedef struct packed {
        vector_t     vector;
        error_code_t error_code;
        eip_t        eip;
        logic        nested;
    } delivery_t;

    // what the microcode loads, 57 bits
    typedef struct packed {
        vector_t     vector;
        error_code_t error_code;
        logic        push_error;
        eip_t        eip;
    } exc_event_t;

    // DE and TS..GP are contributory
    function automatic fault_class_t fault_class_of(vector_t v);
        if (v == VEC_DE || (v >= VEC_TS && v <= VEC_GP)) return CLASS_CONTRIBUTORY;
        if (v == VEC_DF) return CLASS_DOUBLE_FAULT;
        if (v == VEC_PF) return CLASS_PAGE_FAULT;
        return CLASS_BENIGN;
    endfunction

endpackage

`default_nettype wire

//--- verilog/exception_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exception_unit import exc_pkg::*; #(
    parameter int SHUTDOWN_DEPTH = 3
) (
    input  logic         clk,
    input  logic         rst_n,

    // stage fault reports
    input  stage_fault_t dec_fault,
    input  stage_fault_t rd_fault,
    input  stage_fault_t exe_fault,
    input  stage_fault_t wr_fault,

    input  logic         real_mode,
    input  logic         handler_done,

    // microcode side
    output logic         exc_load,
    output exc_event_t   exc_event,
    output logic         pipe_reset,
    output logic         shutdown
);

    // ------------------------------------------------------------
    // internal links
    // ------------------------------------------------------------

    logic       capture_ready;
    logic       req_valid;
    fault_req_t req;
    logic       deliver;
    delivery_t  dlv;
    logic       halt;

    // priority pick and eip
    fault_capture u_fault_capture (
        .clk           (clk),
        .rst_n         (rst_n),
        .dec_fault     (dec_fault),
        .rd_fault      (rd_fault),
        .exe_fault     (exe_fault),
        .wr_fault      (wr_fault),
        .capture_ready (capture_ready),
        .req_valid     (req_valid),
        .req           (req)
    );

    // nesting, promotion, shutdown
    fault_tracker #(
        .SHUTDOWN_DEPTH (SHUTDOWN_DEPTH)
    ) u_fault_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .handler_done  (handler_done),
        .capture_ready (capture_ready),
        .deliver       (deliver),
        .dlv           (dlv),
        .halt          (halt)
    );

    // error code format and load strobe
    exc_output u_exc_output (
        .clk        (clk),
        .rst_n      (rst_n),
        .deliver    (deliver),
        .dlv        (dlv),
        .halt       (halt),
        .real_mode  (real_mode),
        .exc_load   (exc_load),
        .exc_event  (exc_event),
        .pipe_reset (pipe_reset),
        .shutdown   (shutdown)
    );

endmodule

`default_nettype wire

//--- verilog/fault_capture.sv
`timescale 1ns/1ps
`default_nettype none

module fault_capture import exc_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,

    // stage reports
    input  stage_fault_t dec_fault,
    input  stage_fault_t rd_fault,
    input  stage_fault_t exe_fault,
    input  stage_fault_t wr_fault,

    // from tracker
    input  logic         capture_ready,

    // request to tracker
    output logic         req_valid,
    output fault_req_t   req
);

    // ------------------------------------------------------------
    // stage ordering, index 0 wins
    // ------------------------------------------------------------

    localparam int NUM_STAGES = 4;
    localparam int IDX_WR     = 0;
    localparam int IDX_EXE    = 1;
    localparam int IDX_RD     = 2;
    localparam int IDX_DEC    = 3;

    stage_fault_t             stage [NUM_STAGES];
    logic [NUM_STAGES-1:0]    hit;
    logic                     any_hit;
    logic                     take;
    stage_fault_t             sel;
    logic                     sel_is_dec;
    fault_req_t               req_nxt;

    assign stage[IDX_WR]  = wr_fault;
    assign stage[IDX_EXE] = exe_fault;
    assign stage[IDX_RD]  = rd_fault;
    assign stage[IDX_DEC] = dec_fault;

    // only the stage holding the oldest instruction may fault
    always_comb begin
        for (int i = 0; i < NUM_STAGES; i++) begin
            hit[i] = stage[i].valid && stage[i].front;
        end
    end

    assign any_hit = |hit;
    assign take    = capture_ready && any_hit;

    // walk from lowest priority up so the last hit wins
    always_comb begin
        sel        = stage[IDX_DEC];
        sel_is_dec = 1'b1;
        for (int i = NUM_STAGES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                sel        = stage[i];
                sel_is_dec = (i == IDX_DEC);
            end
        end
    end

    // ------------------------------------------------------------
    // faulting eip
    // ------------------------------------------------------------

    // back up over consumed bytes to the instruction start
    // decode has consumed nothing yet
    // traps BP and OF point past the instruction
    function automatic eip_t resolve_eip(stage_fault_t f, logic is_dec);
        logic is_trap;
        is_trap = (f.vector == VEC_BP) || (f.vector == VEC_OF);
        if (is_dec || is_trap) begin
            return f.eip;
        end
        return f.eip - eip_t'(f.consumed);
    endfunction

    always_comb begin
        req_nxt.vector     = sel.vector;
        req_nxt.error_code = sel.error_code;
        req_nxt.eip        = resolve_eip(sel, sel_is_dec);
    end

    // ------------------------------------------------------------
    // request register
    // ------------------------------------------------------------

    // single pulse, tracker drops ready while it is high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= take;
        end
    end

    // payload only moves on a capture
    always_ff @(posedge clk) begin
        if (take) begin
            req <= req_nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fault_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module fault_tracker import exc_pkg::*; #(
    parameter int SHUTDOWN_DEPTH = 3
) (
    input  logic       clk,
    input  logic       rst_n,

    // from capture
    input  logic       req_valid,
    input  fault_req_t req,

    // handler finished, nesting unwinds
    input  logic       handler_done,

    output logic       capture_ready,
    output logic       deliver,
    output delivery_t  dlv,
    output logic       halt
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PROMOTED,
        ST_SHUTDOWN
    } state_t;

    // count never passes SHUTDOWN_DEPTH
    localparam int CNT_W = $clog2(SHUTDOWN_DEPTH + 1);

    state_t           state;
    state_t           state_nxt;
    logic [CNT_W-1:0] count;
    fault_class_t     last_type;
    fault_req_t       promo;
    fault_req_t       cur;
    fault_class_t     cur_class;
    logic             active;
    logic             nested;
    logic             go_shutdown;
    logic             go_promote;

    // ------------------------------------------------------------
    // decision
    // ------------------------------------------------------------

    // promoted DF is re-decided one cycle later
    assign cur       = (state == ST_PROMOTED) ? promo : req;
    assign active    = (state == ST_PROMOTED) || (state == ST_IDLE && req_valid);
    assign cur_class = fault_class_of(cur.vector);
    assign nested    = (count != '0);

    // too deep, or a fault on top of a DF
    assign go_shutdown = active && ((count >= CNT_W'(SHUTDOWN_DEPTH)) ||
                         (nested && last_type == CLASS_DOUBLE_FAULT));

    assign go_promote = active && !go_shutdown && nested &&
                        (cur_class != CLASS_DOUBLE_FAULT) &&
                        ((last_type == CLASS_CONTRIBUTORY && cur_class == CLASS_CONTRIBUTORY) ||
                         (last_type == CLASS_PAGE_FAULT &&
                          (cur_class == CLASS_CONTRIBUTORY || cur_class == CLASS_PAGE_FAULT)));

    assign deliver = active && !go_shutdown && !go_promote;

    always_comb begin
        dlv.vector     = cur.vector;
        dlv.error_code = cur.error_code;
        dlv.eip        = cur.eip;
        dlv.nested     = nested;
    end

    // no new sample while a request is being handled
    assign capture_ready = (state == ST_IDLE) && !req_valid;
    assign halt          = (state == ST_SHUTDOWN);

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE, ST_PROMOTED: begin
                if (go_shutdown) begin
                    state_nxt = ST_SHUTDOWN;
                end else if (go_promote) begin
                    state_nxt = ST_PROMOTED;
                end else if (active) begin
                    state_nxt = ST_IDLE;
                end
            end
            // left only through reset
            ST_SHUTDOWN: state_nxt = ST_SHUTDOWN;
            default:     state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            count     <= '0;
            last_type <= CLASS_BENIGN;
        end else begin
            state <= state_nxt;
            if (handler_done && state != ST_SHUTDOWN) begin
                count <= '0;
            end else if (deliver) begin
                count <= count + 1'b1;
            end
            if (deliver) begin
                last_type <= cur_class;
            end
        end
    end

    // DF carries a zero error code and the original eip
    always_ff @(posedge clk) begin
        if (go_promote) begin
            promo.vector     <= VEC_DF;
            promo.error_code <= '0;
            promo.eip        <= cur.eip;
        end
    end

endmodule

`default_nettype wire
